// File: verilog/issue_defs.svh
/* issue stage widths and counts
   shared by the packages and the issue stage RTL */
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// status rows, one per functional unit (alu, load/store, branch)
`define NUM_FU 3

// datapath word and register index
`define WORD_W 32
`define REG_ADDR_W 5

// age counter per row, saturates at all ones
`define AGE_W 6

// unit operation code carried to execute
`define OP_W 4

`endif

// File: verilog/isa_pkg.sv
/* instruction level types for the issue stage
   data words, register indices and unit opcodes */
`include "issue_defs.svh"

package isa_pkg;

    // one data word as read from or written to the register file
    typedef logic [`WORD_W-1:0] word_t;

    // architectural register index, x0 reads zero
    typedef logic [`REG_ADDR_W-1:0] regbits_t;

    // operation code handed to the selected unit
    typedef logic [`OP_W-1:0] opcode_t;

endpackage

// File: verilog/sched_pkg.sv
/* scheduling types for the issue stage
   row states, producer tags, ages and the structs passed between blocks */
`include "issue_defs.svh"

package sched_pkg;

    // producing unit, 0 means the operand is already in the register file
    // 1..NUM_FU name unit 0..NUM_FU-1
    typedef logic [$clog2(`NUM_FU+1)-1:0] tag_t;

    // row age, larger is older
    typedef logic [`AGE_W-1:0] age_t;

    // row life cycle, ready is folded into wait
    typedef enum logic [1:0] {
        EMPTY,
        WAIT,
        EX
    } fust_state_e;

    // one functional unit status row
    typedef struct packed {
        isa_pkg::regbits_t rs1;
        isa_pkg::regbits_t rs2;
        isa_pkg::regbits_t rd;
        isa_pkg::opcode_t  op;
        logic              i_type;
        logic              lui;
        isa_pkg::word_t    imm;
        tag_t              t1;
        tag_t              t2;
    } fust_row_t;

    // dispatch request, fu selects the target row
    typedef struct packed {
        logic       en;
        logic [1:0] fu;
        fust_row_t  row;
    } dispatch_t;

    // writeback from a unit, tag names that unit
    typedef struct packed {
        logic              en;
        tag_t              tag;
        isa_pkg::regbits_t sel;
        isa_pkg::word_t    wdat;
    } wb_t;

    // issue packet, fu_en is one-hot or zero
    typedef struct packed {
        logic [`NUM_FU-1:0] fu_en;
        isa_pkg::opcode_t   op;
        isa_pkg::regbits_t  rd;
        isa_pkg::word_t     rdat1;
        isa_pkg::word_t     rdat2;
        isa_pkg::word_t     imm;
    } issue_t;

endpackage

// File: verilog/reg_file.sv
/* scalar register file, 32 entries
   one writeback port and two combinational read ports, x0 stays zero */
`timescale 1ns/1ps
`include "issue_defs.svh"

module reg_file (
    input  logic              CLK,
    input  logic              nRST,
    input  sched_pkg::wb_t    wb,
    input  isa_pkg::regbits_t rs1,
    input  isa_pkg::regbits_t rs2,
    output isa_pkg::word_t    rdat1,
    output isa_pkg::word_t    rdat2
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_W;

    isa_pkg::word_t regs [NUM_REGS];

    // entry 0 is cleared on reset and never written
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.sel != '0)) begin
            regs[wb.sel] <= wb.wdat;
        end
    end

    // reads see the value after the last edge, so a wb in cycle k
    // is visible to a pick in cycle k+1
    always_comb begin
        rdat1 = regs[rs1];
        rdat2 = regs[rs2];
    end

endmodule

// File: verilog/fu_status_table.sv
/* functional unit status table, one row per unit
   takes dispatch writes and clears producer tags on writeback */
`timescale 1ns/1ps
`include "issue_defs.svh"

module fu_status_table (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  sched_pkg::dispatch_t                 disp,
    input  sched_pkg::wb_t                       wb,
    input  logic                                 branch_miss,
    output sched_pkg::fust_row_t [`NUM_FU-1:0]   rows
);

    sched_pkg::fust_row_t [`NUM_FU-1:0] rows_n;
    logic [`NUM_FU-1:0]                 wr_hit;

    // decode target row of the dispatch
    // a dispatch alongside a branch miss is thrown away
    always_comb begin
        wr_hit = '0;
        for (int i = 0; i < `NUM_FU; i++) begin
            wr_hit[i] = disp.en && !branch_miss && (disp.fu == 2'(i));
        end
    end

    always_comb begin
        rows_n = rows;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (wr_hit[i]) begin
                rows_n[i] = disp.row;
            end
            // tag clear also covers the row being written this cycle
            if (wb.en) begin
                if (rows_n[i].t1 == wb.tag) begin
                    rows_n[i].t1 = '0;
                end
                if (rows_n[i].t2 == wb.tag) begin
                    rows_n[i].t2 = '0;
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= rows_n;
        end
    end

endmodule

// File: verilog/issue_select.sv
/* issue select, row FSMs and ages
   picks the oldest waiting row whose operands are both available */
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_select (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  sched_pkg::dispatch_t                 disp,
    input  sched_pkg::fust_row_t [`NUM_FU-1:0]   rows,
    input  logic [`NUM_FU-1:0]                   fu_done,
    input  logic                                 branch_miss,
    input  logic                                 freeze,
    output logic [`NUM_FU-1:0]                   pick,
    output sched_pkg::fust_state_e [`NUM_FU-1:0] state
);

    sched_pkg::fust_state_e [`NUM_FU-1:0] state_n;
    sched_pkg::age_t [`NUM_FU-1:0]        age;
    sched_pkg::age_t [`NUM_FU-1:0]        age_n;
    logic [`NUM_FU-1:0]                   elig;
    logic [`NUM_FU-1:0]                   hit;
    sched_pkg::age_t                      best;
    logic                                 found;

    // readiness comes straight from the registered tags
    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            elig[i] = (state[i] == sched_pkg::WAIT) && (rows[i].t1 == '0) &&
                      (rows[i].t2 == '0) && !freeze && !branch_miss;
            hit[i]  = disp.en && (disp.fu == 2'(i));
        end
    end

    // oldest first, strict compare keeps ties on the lower index
    always_comb begin
        pick  = '0;
        best  = '0;
        found = 1'b0;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (elig[i] && (!found || (age[i] > best))) begin
                pick  = '0;
                pick[i] = 1'b1;
                best  = age[i];
                found = 1'b1;
            end
        end
    end

    always_comb begin
        state_n = state;
        age_n   = age;
        for (int i = 0; i < `NUM_FU; i++) begin
            case (state[i])
                sched_pkg::EMPTY: if (hit[i]) state_n[i] = sched_pkg::WAIT;
                sched_pkg::WAIT:  if (pick[i]) state_n[i] = sched_pkg::EX;
                sched_pkg::EX: begin
                    // completion frees the row, back-to-back dispatch refills it
                    if (fu_done[i]) begin
                        state_n[i] = hit[i] ? sched_pkg::WAIT : sched_pkg::EMPTY;
                    end
                end
                default: state_n[i] = sched_pkg::EMPTY;
            endcase
            // ages, every waiting row grows older on each new dispatch
            if (pick[i]) begin
                age_n[i] = '0;
            end else if (hit[i] && (state_n[i] == sched_pkg::WAIT)) begin
                age_n[i] = sched_pkg::age_t'(1);
            end else if (disp.en && (state[i] == sched_pkg::WAIT) && (age[i] != '1)) begin
                age_n[i] = age[i] + 1'b1;
            end
            // flush wins over everything
            if (branch_miss) begin
                state_n[i] = sched_pkg::EMPTY;
                age_n[i]   = '0;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= {`NUM_FU{sched_pkg::EMPTY}};
            age   <= '0;
        end else begin
            state <= state_n;
            age   <= age_n;
        end
    end

endmodule

// File: verilog/issue_latch.sv
/* issue latch, builds the operands of the picked row
   and registers the issue packet, held by freeze and cleared by flush */
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_latch (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  sched_pkg::fust_row_t [`NUM_FU-1:0]   rows,
    input  logic [`NUM_FU-1:0]                   pick,
    input  isa_pkg::word_t                       rdat1,
    input  isa_pkg::word_t                       rdat2,
    output isa_pkg::regbits_t                    rs1,
    output isa_pkg::regbits_t                    rs2,
    input  logic                                 branch_miss,
    input  logic                                 freeze,
    output sched_pkg::issue_t                    out
);

    // row 0 belongs to the alu, the only unit that takes the immediate
    localparam int ALU_ROW = 0;

    sched_pkg::fust_row_t sel_row;
    sched_pkg::issue_t    out_n;

    // pick is one-hot or zero, so an or-mux is enough
    always_comb begin
        sel_row = '0;
        for (int i = 0; i < `NUM_FU; i++) begin
            if (pick[i]) begin
                sel_row = sel_row | rows[i];
            end
        end
        rs1 = sel_row.rs1;
        rs2 = sel_row.rs2;
    end

    always_comb begin
        out_n.fu_en = pick;
        out_n.op    = sel_row.op;
        out_n.rd    = sel_row.rd;
        out_n.imm   = sel_row.imm;
        // lui adds its immediate to zero
        out_n.rdat1 = sel_row.lui ? '0 : rdat1;
        // branches keep rs2 for the compare even with i_type set
        out_n.rdat2 = (sel_row.i_type && pick[ALU_ROW]) ? sel_row.imm : rdat2;
        if (!(|pick) || branch_miss) begin
            out_n = '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (!freeze) begin
            out <= out_n;
        end
    end

endmodule

// File: verilog/issue_top.sv
/* issue stage top, status table, select, latch and register file
   busy marks every row that is not empty */
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  sched_pkg::dispatch_t disp,
    input  sched_pkg::wb_t       wb,
    input  logic [`NUM_FU-1:0]   fu_done,
    input  logic                 branch_miss,
    input  logic                 freeze,
    output sched_pkg::issue_t    out,
    output logic [`NUM_FU-1:0]   busy
);

    sched_pkg::fust_row_t [`NUM_FU-1:0]   rows;
    sched_pkg::fust_state_e [`NUM_FU-1:0] state;
    logic [`NUM_FU-1:0]                   pick;
    isa_pkg::regbits_t                    rs1;
    isa_pkg::regbits_t                    rs2;
    isa_pkg::word_t                       rdat1;
    isa_pkg::word_t                       rdat2;

    reg_file u_rf (
        .CLK(CLK), .nRST(nRST), .wb(wb),
        .rs1(rs1), .rs2(rs2), .rdat1(rdat1), .rdat2(rdat2)
    );

    fu_status_table u_fust (
        .CLK(CLK), .nRST(nRST), .disp(disp), .wb(wb),
        .branch_miss(branch_miss), .rows(rows)
    );

    issue_select u_sel (
        .CLK(CLK), .nRST(nRST), .disp(disp), .rows(rows), .fu_done(fu_done),
        .branch_miss(branch_miss), .freeze(freeze), .pick(pick), .state(state)
    );

    issue_latch u_latch (
        .CLK(CLK), .nRST(nRST), .rows(rows), .pick(pick),
        .rdat1(rdat1), .rdat2(rdat2), .rs1(rs1), .rs2(rs2),
        .branch_miss(branch_miss), .freeze(freeze), .out(out)
    );

    // a row is busy from dispatch until its unit reports done
    always_comb begin
        for (int i = 0; i < `NUM_FU; i++) begin
            busy[i] = (state[i] != sched_pkg::EMPTY);
        end
    end

endmodule

// File: sim/issue_chk.sv
/* issue stage assertions, bound into the top level
   one-hot issue, flush empties every row, freeze holds the packet */
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_chk (
    input logic                CLK,
    input logic                nRST,
    input logic                branch_miss,
    input logic                freeze,
    input sched_pkg::issue_t   out,
    input logic [`NUM_FU-1:0]  busy
);

    // failures so far, the testbench folds these into its verdict
    int fails = 0;

    // at most one unit receives the packet
    fu_en_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(out.fu_en))
        else begin
            $error("issue packet enables more than one unit");
            fails++;
        end

    // a flush leaves no row busy on the next cycle
    flush_empties: assert property (@(posedge CLK) disable iff (!nRST)
        branch_miss |=> (busy == '0))
        else begin
            $error("rows still busy one cycle after branch miss");
            fails++;
        end

    // freeze keeps the registered packet
    freeze_holds: assert property (@(posedge CLK) disable iff (!nRST)
        freeze |=> $stable(out))
        else begin
            $error("issue packet changed while frozen");
            fails++;
        end

endmodule

// File: sim/tb_issue.sv
/* testbench for the issue stage top level
   replays the step file one line per cycle and checks the issue packet and busy */
`timescale 1ns/1ps
`include "issue_defs.svh"

module tb_issue;

    localparam int CLK_HALF   = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int RST_CYCLES = 4;

    // one cycle of stimulus plus the expected outputs for that cycle
    typedef struct packed {
        sched_pkg::dispatch_t disp;
        sched_pkg::wb_t       wb;
        logic [`NUM_FU-1:0]   fu_done;
        logic                 branch_miss;
        logic                 freeze;
        logic [4:0]           mask;
        logic [`NUM_FU-1:0]   fu_en;
        isa_pkg::word_t       rdat1;
        isa_pkg::word_t       rdat2;
        isa_pkg::regbits_t    rd;
        logic [`NUM_FU-1:0]   busy;
    } step_t;

    logic                 CLK;
    logic                 nRST;
    sched_pkg::dispatch_t disp;
    sched_pkg::wb_t       wb;
    logic [`NUM_FU-1:0]   fu_done;
    logic                 branch_miss;
    logic                 freeze;
    sched_pkg::issue_t    out;
    logic [`NUM_FU-1:0]   busy;

    step_t steps[$];
    string names[$];
    int    checks = 0;
    int    errors = 0;
    int    tests = 0;
    int    test_checks = 0;
    int    test_errs = 0;
    int    cycles = 0;
    int    cycle_limit = 1000;

    // last row dispatched to each unit, gives the op and imm an issue must carry
    sched_pkg::fust_row_t last_row [`NUM_FU];

    issue_top uut (
        .CLK(CLK), .nRST(nRST), .disp(disp), .wb(wb), .fu_done(fu_done),
        .branch_miss(branch_miss), .freeze(freeze), .out(out), .busy(busy)
    );

    bind issue_top issue_chk chk (
        .CLK(CLK), .nRST(nRST), .branch_miss(branch_miss), .freeze(freeze),
        .out(out), .busy(busy)
    );

    always #CLK_HALF CLK = ~CLK;

    // run length bound, limit is set once the step file is loaded
    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no end of test after %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // read the step file, comment and blank lines skipped
    function automatic int load_steps();
        int          fd;
        int          n;
        string       line;
        string       name;
        step_t       s;
        logic [31:0] f [24];
        fd = $fopen("sim/issue_testdata.txt", "r");
        if (fd == 0) begin
            return 0;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                    f[19], f[20], f[21], f[22], f[23]);
                if (n != 25) begin
                    $fclose(fd);
                    return 0;
                end
                s.disp.en          = f[0][0];
                s.disp.fu          = f[1][1:0];
                s.disp.row.rs1     = f[2][4:0];
                s.disp.row.rs2     = f[3][4:0];
                s.disp.row.rd      = f[4][4:0];
                s.disp.row.op      = f[5][3:0];
                s.disp.row.i_type  = f[6][0];
                s.disp.row.lui     = f[7][0];
                s.disp.row.imm     = f[8];
                s.disp.row.t1      = f[9][1:0];
                s.disp.row.t2      = f[10][1:0];
                s.wb.en            = f[11][0];
                s.wb.tag           = f[12][1:0];
                s.wb.sel           = f[13][4:0];
                s.wb.wdat          = f[14];
                s.fu_done          = f[15][2:0];
                s.branch_miss      = f[16][0];
                s.freeze           = f[17][0];
                // expected side
                s.mask             = f[18][4:0];
                s.fu_en            = f[19][2:0];
                s.rdat1            = f[20];
                s.rdat2            = f[21];
                s.rd               = f[22][4:0];
                s.busy             = f[23][2:0];
                steps.push_back(s);
                names.push_back(name);
            end
        end
        $fclose(fd);
        return (steps.size() > 0) ? 1 : 0;
    endfunction

    task automatic apply_step(input step_t s);
        disp        = s.disp;
        wb          = s.wb;
        fu_done     = s.fu_done;
        branch_miss = s.branch_miss;
        freeze      = s.freeze;
    endtask

    // dispatch beside a branch miss never reaches a row
    task automatic record_dispatch(input step_t s);
        if (s.disp.en && !s.branch_miss) begin
            last_row[s.disp.fu] = s.disp.row;
        end
    endtask

    task automatic compare(input string test, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
        checks++;
        test_checks++;
        if (act !== exp) begin
            $display("ERR %s %s expected %h actual %h", test, field, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    // op and imm come from the row named by the expected fu_en, zero when idle
    task automatic check_payload(input string test, input step_t s);
        isa_pkg::opcode_t exp_op;
        isa_pkg::word_t   exp_imm;
        exp_op  = '0;
        exp_imm = '0;
        for (int u = 0; u < `NUM_FU; u++) begin
            if (s.fu_en[u]) begin
                exp_op  = last_row[u].op;
                exp_imm = last_row[u].imm;
            end
        end
        compare(test, "op", 32'(exp_op), 32'(out.op));
        compare(test, "imm", exp_imm, out.imm);
    endtask

    // mask picks the fields that matter on this cycle
    task automatic check_step(input string test, input step_t s);
        if (s.mask[0]) compare(test, "fu_en", 32'(s.fu_en), 32'(out.fu_en));
        if (s.mask[0]) check_payload(test, s);
        if (s.mask[1]) compare(test, "rdat1", s.rdat1, out.rdat1);
        if (s.mask[2]) compare(test, "rdat2", s.rdat2, out.rdat2);
        if (s.mask[3]) compare(test, "rd", 32'(s.rd), 32'(out.rd));
        if (s.mask[4]) compare(test, "busy", 32'(s.busy), 32'(busy));
    endtask

    task automatic close_test(input string test);
        $display("test %s finished, %0d checks, %0d errors", test, test_checks, test_errs);
        tests++;
        test_checks = 0;
        test_errs = 0;
    endtask

    initial begin : main
        int    ok;
        string cur;
        CLK         = 1'b0;
        nRST        = 1'b0;
        disp        = '0;
        wb          = '0;
        fu_done     = '0;
        branch_miss = 1'b0;
        freeze      = 1'b0;
        for (int u = 0; u < `NUM_FU; u++) begin
            last_row[u] = '0;
        end
        ok = load_steps();
        if (ok == 0) begin
            $display("stimulus file sim/issue_testdata.txt is missing or malformed");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            cycle_limit = steps.size() + 20;
            repeat (RST_CYCLES) @(posedge CLK);
            #DRIVE_DLY;
            nRST = 1'b1;
            cur = names[0];
            for (int i = 0; i < steps.size(); i++) begin
                // inputs change just after the edge, outputs are read mid cycle
                if (i > 0) begin
                    @(posedge CLK);
                    #DRIVE_DLY;
                end
                if (names[i] != cur) begin
                    close_test(cur);
                    cur = names[i];
                end
                apply_step(steps[i]);
                @(negedge CLK);
                check_step(names[i], steps[i]);
                // a row written now shows up in the packet two cycles later
                record_dispatch(steps[i]);
            end
            close_test(cur);
            $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                     tests, checks, errors, uut.chk.fails);
            if (errors == 0 && uut.chk.fails == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: src.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/sched_pkg.sv
verilog/reg_file.sv
verilog/fu_status_table.sv
verilog/issue_select.sv
verilog/issue_latch.sv
verilog/issue_top.sv
sim/issue_chk.sv
sim/tb_issue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = tb_issue
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides, the simulator exit code alone is not trusted
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/issue_testdata.txt
# name d_en d_fu rs1 rs2 rd op i_type lui imm t1 t2 wb_en wb_tag wb_sel wb_wdat fu_done br_miss frz
# then mask (1 fu_en 2 rdat1 4 rdat2 8 rd 10 busy) and expected fu_en rdat1 rdat2 rd busy, all hex
wbrd 0 0 0 0 0 0 0 0 0 0 0 1 1 01 11111111 0 0 0 11 0 0 0 0 0
wbrd 0 0 0 0 0 0 0 0 0 0 0 1 1 02 22222222 0 0 0 11 0 0 0 0 0
wbrd 1 1 01 02 03 5 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
wbrd 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 2
wbrd 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 1f 2 11111111 22222222 03 2
wbrd 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
imm 1 0 01 02 04 1 1 0 abc 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
imm 1 2 02 01 00 3 1 0 10 0 0 0 0 0 0 0 0 0 11 0 0 0 0 1
imm 1 1 01 02 05 2 0 1 12345000 0 0 0 0 0 0 1 0 0 1f 1 11111111 abc 04 5
imm 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 1f 4 22222222 11111111 00 6
imm 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 1f 2 0 22222222 05 2
imm 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
tagw 1 0 06 01 07 4 0 0 0 2 0 0 0 0 0 0 0 0 11 0 0 0 0 0
tagw 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 1
tagw 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 1
tagw 0 0 0 0 0 0 0 0 0 0 0 1 2 06 66666666 0 0 0 11 0 0 0 0 1
tagw 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 1
tagw 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1f 1 66666666 11111111 07 1
tagw 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
two 1 1 03 06 08 6 0 0 0 1 0 0 0 0 0 0 0 0 11 0 0 0 0 0
two 1 2 01 03 09 7 0 0 0 0 1 0 0 0 0 0 0 0 11 0 0 0 0 2
two 0 0 0 0 0 0 0 0 0 0 0 1 1 03 33333333 0 0 0 11 0 0 0 0 6
two 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 6
two 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 1f 2 33333333 66666666 08 6
two 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 1f 4 11111111 33333333 09 4
two 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
bmiss 1 0 01 02 0a 1 0 0 0 3 0 0 0 0 0 0 0 0 11 0 0 0 0 0
bmiss 1 1 02 01 0b 2 0 0 0 0 3 0 0 0 0 0 0 0 11 0 0 0 0 1
bmiss 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 11 0 0 0 0 3
bmiss 0 0 0 0 0 0 0 0 0 0 0 1 3 0c 0c0c0c0c 0 0 0 11 0 0 0 0 0
bmiss 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
bmiss 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
frz 1 0 01 0c 0e 8 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
frz 1 2 0c 02 0d 9 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 1
frz 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1f 1 11111111 0c0c0c0c 0e 5
frz 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1f 1 11111111 0c0c0c0c 0e 5
frz 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1f 1 11111111 0c0c0c0c 0e 5
frz 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1f 1 11111111 0c0c0c0c 0e 5
frz 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 1f 4 0c0c0c0c 22222222 0d 4
frz 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 0 0 0 0 0
